//--- source/cpuPkg.sv
`default_nettype none

package cpuPkg;

  // Machine word for registers, data, addresses and PC
  parameter int dataWidth = 16;

  // Reserved data address, stores here go to the output register
  parameter logic [dataWidth-1:0] ioAddr = 16'h03FF;

  typedef enum logic [3:0] {
    opAdd = 4'd0,
    opSub = 4'd1,
    opLd  = 4'd2,
    opSt  = 4'd3,
    opLda = 4'd4,
    opSta = 4'd5,
    opBz  = 4'd6,
    opJmp = 4'd7,
    opJr  = 4'd8
  } opcode_t;

  // Register form, three register fields
  typedef struct packed {
    opcode_t    opcode;
    logic [1:0] rd;
    logic [1:0] rs1;
    logic [1:0] rs2;
    logic [5:0] unused;
  } regForm_t;

  // Absolute address or branch offset form
  typedef struct packed {
    opcode_t    opcode;
    logic [1:0] regSel;
    logic [9:0] addr;
  } addrForm_t;

  typedef union packed {
    regForm_t  regForm;
    addrForm_t addrForm;
  } instr_t;

  typedef enum logic [1:0] {
    pcInc = 2'd0,
    pcRel = 2'd1,
    pcReg = 2'd2
  } pcSel_t;

  typedef enum logic {
    aluAdd = 1'b0,
    aluSub = 1'b1
  } aluOp_t;

  // One word of program or data loading, toData picks data memory
  typedef struct packed {
    logic                 en;
    logic                 toData;
    logic [9:0]           addr;
    logic [dataWidth-1:0] data;
  } loadReq_t;

endpackage

`default_nettype wire

//--- source/registerFile.sv
`timescale 1ns/10ps
`default_nettype none

module registerFile (
  input  wire  logic                         clk,
  input  wire  logic                         rst,
  input  wire  logic                         we,
  input  wire  logic [1:0]                   wsel,
  input  wire  logic [cpuPkg::dataWidth-1:0] wdata,
  input  wire  logic [1:0]                   rsel1,
  input  wire  logic [1:0]                   rsel2,
  output logic       [cpuPkg::dataWidth-1:0] rdata1,
  output logic       [cpuPkg::dataWidth-1:0] rdata2
);

  logic [cpuPkg::dataWidth-1:0] regs [4];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 4; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wsel] <= wdata;
    end
  end

  // Reads see the old value during a write, no bypass
  assign rdata1 = regs[rsel1];
  assign rdata2 = regs[rsel2];

  // A write with an unknown target would corrupt an arbitrary register
  wselKnown: assert property (
    @(posedge clk) disable iff (rst) we |-> !$isunknown(wsel)
  ) else $error("register write with unknown select");

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  wire  logic                         clk,
  input  wire  logic                         rst,
  input  wire  logic                         en,
  input  wire  cpuPkg::aluOp_t               op,
  input  wire  logic [cpuPkg::dataWidth-1:0] a,
  input  wire  logic [cpuPkg::dataWidth-1:0] b,
  output logic       [cpuPkg::dataWidth-1:0] result,
  output logic                               zFlag
);

  always_comb begin
    if (op == cpuPkg::aluSub) begin
      result = a - b;
    end else begin
      result = a + b;
    end
  end

  // Flag follows the latest add or subtract only
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      zFlag <= 1'b0;
    end else if (en) begin
      zFlag <= (result == '0);
    end
  end

endmodule

`default_nettype wire

//--- source/instrDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
  input  wire  cpuPkg::instr_t instr,
  input  wire  logic           zFlag,
  input  wire  logic           run,
  output logic [1:0]           regWsel,
  output logic [1:0]           regRsel1,
  output logic [1:0]           regRsel2,
  output logic                 regWe,
  output logic                 regInFromMem,
  output cpuPkg::aluOp_t       aluOp,
  output logic                 flagEn,
  output logic                 dWe,
  output logic                 dAddrFromReg,
  output logic [9:0]           addrField,
  output cpuPkg::pcSel_t       pcSel
);

  always_comb begin
    // Register form fields unless an opcode says otherwise
    regWsel      = instr.regForm.rd;
    regRsel1     = instr.regForm.rs1;
    regRsel2     = instr.regForm.rs2;
    regWe        = 1'b0;
    regInFromMem = 1'b0;
    aluOp        = cpuPkg::aluAdd;
    flagEn       = 1'b0;
    dWe          = 1'b0;
    dAddrFromReg = 1'b0;
    addrField    = instr.addrForm.addr;
    pcSel        = cpuPkg::pcInc;

    case (instr.regForm.opcode)
      cpuPkg::opAdd: begin
        regWe  = run;
        flagEn = run;
      end
      cpuPkg::opSub: begin
        aluOp  = cpuPkg::aluSub;
        regWe  = run;
        flagEn = run;
      end
      cpuPkg::opLd: begin
        regWe        = run;
        regInFromMem = 1'b1;
        dAddrFromReg = 1'b1;
      end
      cpuPkg::opSt: begin
        dWe          = run;
        dAddrFromReg = 1'b1;
      end
      cpuPkg::opLda: begin
        regWsel      = instr.addrForm.regSel;
        regWe        = run;
        regInFromMem = 1'b1;
      end
      cpuPkg::opSta: begin
        // Store data always leaves through read port 2
        regRsel2 = instr.addrForm.regSel;
        dWe      = run;
      end
      cpuPkg::opBz: begin
        pcSel = zFlag ? cpuPkg::pcRel : cpuPkg::pcInc;
      end
      cpuPkg::opJmp: pcSel = cpuPkg::pcRel;
      cpuPkg::opJr:  pcSel = cpuPkg::pcReg;
      default: ;
    endcase
  end

  // Only one destination is written per instruction
  oneWriteTarget: assert final (!(regWe && dWe))
    else $error("register and memory write raised together");

endmodule

`default_nettype wire

//--- source/pcUnit.sv
`timescale 1ns/10ps
`default_nettype none

module pcUnit (
  input  wire  logic                         clk,
  input  wire  logic                         rst,
  input  wire  logic                         run,
  input  wire  cpuPkg::pcSel_t               pcSel,
  input  wire  logic [9:0]                   offset,
  input  wire  logic [cpuPkg::dataWidth-1:0] target,
  output logic       [cpuPkg::dataWidth-1:0] pc
);

  logic [cpuPkg::dataWidth-1:0] nextPc;
  logic [cpuPkg::dataWidth-1:0] relOffset;

  // Branch offsets are signed
  assign relOffset = {{(cpuPkg::dataWidth - 10){offset[9]}}, offset};

  always_comb begin
    case (pcSel)
      cpuPkg::pcRel: nextPc = pc + relOffset;
      cpuPkg::pcReg: nextPc = target;
      default:       nextPc = pc + 1'b1;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (run) begin
      pc <= nextPc;
    end
  end

endmodule

`default_nettype wire

//--- source/memorySystem.sv
`timescale 1ns/10ps
`default_nettype none

module memorySystem #(
  parameter int addrBits = 10
) (
  input  wire  logic                         clk,
  input  wire  logic                         rst,
  input  wire  logic                         run,
  input  wire  cpuPkg::loadReq_t             load,
  input  wire  logic [cpuPkg::dataWidth-1:0] pc,
  output cpuPkg::instr_t                     instr,
  input  wire  logic [cpuPkg::dataWidth-1:0] dAddr,
  input  wire  logic [cpuPkg::dataWidth-1:0] dWdata,
  input  wire  logic                         dWe,
  output logic       [cpuPkg::dataWidth-1:0] dRdata,
  output logic       [cpuPkg::dataWidth-1:0] ioOut,
  output logic                               ioStrobe
);

  localparam int depth = 2 ** addrBits;

  logic [cpuPkg::dataWidth-1:0] iMem [depth];
  logic [cpuPkg::dataWidth-1:0] dMem [depth];

  logic loadWe;
  logic ioWrite;
  logic memWrite;

  assign loadWe   = load.en && !run;
  assign ioWrite  = dWe && run && (dAddr == cpuPkg::ioAddr);
  assign memWrite = dWe && run && (dAddr != cpuPkg::ioAddr);

  // Program memory is only written by the load port
  always_ff @(posedge clk) begin
    if (loadWe && !load.toData) begin
      iMem[addrBits'(load.addr)] <= load.data;
    end
  end

  // Data memory, loaded while stopped, stored to while running
  always_ff @(posedge clk) begin
    if (loadWe && load.toData) begin
      dMem[addrBits'(load.addr)] <= load.data;
    end else if (memWrite) begin
      dMem[addrBits'(dAddr)] <= dWdata;
    end
  end

  assign instr  = iMem[addrBits'(pc)];
  assign dRdata = dMem[addrBits'(dAddr)];

  // Memory-mapped output port, strobe lasts one cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ioOut    <= '0;
      ioStrobe <= 1'b0;
    end else begin
      ioStrobe <= ioWrite;
      if (ioWrite) begin
        ioOut <= dWdata;
      end
    end
  end

  // Loads are only meaningful while the CPU is stopped
  noLoadWhileRunning: assert property (
    @(posedge clk) disable iff (rst) !(load.en && run)
  ) else $error("load strobe ignored because run is high");

endmodule

`default_nettype wire

//--- source/processor.sv
`timescale 1ns/10ps
`default_nettype none

module processor #(
  parameter int memAddrBits = 10
) (
  input  wire  logic                         clk,
  input  wire  logic                         rst,
  input  wire  logic                         run,
  input  wire  cpuPkg::loadReq_t             load,
  output logic       [cpuPkg::dataWidth-1:0] ioOut,
  output logic                               ioStrobe,
  output logic       [7:0]                   led
);

  cpuPkg::instr_t instr;
  cpuPkg::aluOp_t aluOp;
  cpuPkg::pcSel_t pcSel;

  logic [1:0] regWsel;
  logic [1:0] regRsel1;
  logic [1:0] regRsel2;
  logic       regWe;
  logic       regInFromMem;
  logic       flagEn;
  logic       zFlag;
  logic       dWe;
  logic       dAddrFromReg;
  logic [9:0] addrField;

  logic [cpuPkg::dataWidth-1:0] rdata1;
  logic [cpuPkg::dataWidth-1:0] rdata2;
  logic [cpuPkg::dataWidth-1:0] aluResult;
  logic [cpuPkg::dataWidth-1:0] regIn;
  logic [cpuPkg::dataWidth-1:0] dAddr;
  logic [cpuPkg::dataWidth-1:0] dRdata;
  logic [cpuPkg::dataWidth-1:0] pc;

  // Write-back source and data address source
  assign regIn = regInFromMem ? dRdata : aluResult;
  assign dAddr = dAddrFromReg ? rdata1 : {{(cpuPkg::dataWidth - 10){1'b0}}, addrField};
  assign led   = pc[7:0];

  registerFile regFile (
    .clk(clk), .rst(rst), .we(regWe), .wsel(regWsel), .wdata(regIn),
    .rsel1(regRsel1), .rsel2(regRsel2), .rdata1(rdata1), .rdata2(rdata2)
  );

  alu aluUnit (
    .clk(clk), .rst(rst), .en(flagEn), .op(aluOp), .a(rdata1), .b(rdata2),
    .result(aluResult), .zFlag(zFlag)
  );

  instrDecoder decoder (
    .instr(instr), .zFlag(zFlag), .run(run), .regWsel(regWsel), .regRsel1(regRsel1),
    .regRsel2(regRsel2), .regWe(regWe), .regInFromMem(regInFromMem), .aluOp(aluOp),
    .flagEn(flagEn), .dWe(dWe), .dAddrFromReg(dAddrFromReg), .addrField(addrField),
    .pcSel(pcSel)
  );

  pcUnit pcCtrl (
    .clk(clk), .rst(rst), .run(run), .pcSel(pcSel), .offset(addrField),
    .target(rdata1), .pc(pc)
  );

  // Stored data always comes from read port 2
  memorySystem #(.addrBits(memAddrBits)) mem (
    .clk(clk), .rst(rst), .run(run), .load(load), .pc(pc), .instr(instr),
    .dAddr(dAddr), .dWdata(rdata2), .dWe(dWe), .dRdata(dRdata),
    .ioOut(ioOut), .ioStrobe(ioStrobe)
  );

endmodule

`default_nettype wire

//--- dv/processorTb.sv
`timescale 1ns/10ps
`default_nettype none

module processorTb;

  localparam int goldenDepth   = 256;
  localparam int strobeTimeout = 200;
  localparam int quietCycles   = 16;

  // Record kinds in the golden file
  localparam logic [3:0] recEnd    = 4'h0;
  localparam logic [3:0] recLoad   = 4'h1;
  localparam logic [3:0] recRun    = 4'h2;
  localparam logic [3:0] recExpect = 4'h3;
  localparam logic [3:0] recEndPc  = 4'h4;

  logic                         clk;
  logic                         rst;
  logic                         run;
  cpuPkg::loadReq_t             load;
  logic [cpuPkg::dataWidth-1:0] ioOut;
  logic                         ioStrobe;
  logic [7:0]                   led;
  int                           strobeCount;

  // kind, target, address, data
  logic [35:0] golden [goldenDepth];

  processor #(.memAddrBits(10)) processor_i (
    .clk(clk), .rst(rst), .run(run), .load(load),
    .ioOut(ioOut), .ioStrobe(ioStrobe), .led(led)
  );

  always #5 clk = ~clk;

  // Counts every output pulse since the last reset
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      strobeCount <= 0;
    end else if (ioStrobe) begin
      strobeCount <= strobeCount + 1;
    end
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Outputs stay idle while the CPU is stopped
  task automatic checkIdle(input string phase);
    checkEqual(ioStrobe, 1'b0, {"ioStrobe during ", phase});
    checkEqual(led, 8'h00, {"led during ", phase});
  endtask

  task automatic applyReset();
    @(posedge clk);
    rst  <= 1'b1;
    run  <= 1'b0;
    load <= '0;
    repeat (8) begin
      @(negedge clk);
      checkIdle("reset");
    end
    @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic loadWord(input logic toData, input logic [9:0] addr,
                          input logic [15:0] data);
    cpuPkg::loadReq_t req;
    req.en     = 1'b1;
    req.toData = toData;
    req.addr   = addr;
    req.data   = data;
    @(posedge clk);
    load <= req;
    @(negedge clk);
    checkIdle("loading");
  endtask

  // Last load word is still taken at this edge since run rises with it
  task automatic startRun();
    @(posedge clk);
    load <= '0;
    run  <= 1'b1;
  endtask

  task automatic awaitOutput(input logic [15:0] expected, input int index);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (ioStrobe !== 1'b1) begin
      if (cycles >= strobeTimeout) begin
        abortRun($sformatf("Timeout: output %0d never came within %0d cycles",
                           index, strobeTimeout));
      end
      cycles++;
      @(negedge clk);
    end
    checkEqual(ioOut, expected, $sformatf("ioOut of output %0d", index));
  endtask

  // No further output may appear once the program sits in its self loop
  task automatic watchQuiet();
    repeat (quietCycles) begin
      @(negedge clk);
      checkEqual(ioStrobe, 1'b0, "ioStrobe after the last expected output");
    end
  endtask

  initial begin
    int          idx;
    int          expectedCount;
    int          seenCount;
    logic        loading;
    logic [3:0]  kind;
    logic [15:0] value;

    clk           = 1'b0;
    rst           = 1'b1;
    run           = 1'b0;
    load          = '0;
    idx           = 0;
    expectedCount = 0;
    seenCount     = 0;
    loading       = 1'b0;

    $readmemh("dv/processorGolden.txt", golden);
    if ($isunknown(golden[0])) begin
      abortRun("Golden file dv/processorGolden.txt could not be read");
    end

    kind = golden[0][35:32];
    while (kind !== recEnd) begin
      value = golden[idx][15:0];
      case (kind)
        recLoad: begin
          // First load of a program starts with a fresh reset
          if (!loading) begin
            applyReset();
            loading = 1'b1;
          end
          loadWord(golden[idx][28], golden[idx][25:16], value);
        end
        recRun: begin
          startRun();
          expectedCount = value;
          seenCount     = 0;
          loading       = 1'b0;
        end
        recExpect: begin
          seenCount++;
          awaitOutput(value, seenCount);
        end
        recEndPc: begin
          checkEqual(led, value[7:0], "led at end of program");
          watchQuiet();
          checkEqual(strobeCount, expectedCount, "number of outputs in the run");
          @(posedge clk);
          run <= 1'b0;
        end
        default: begin
          abortRun($sformatf("Golden file record %0d has an unknown kind", idx));
        end
      endcase
      idx++;
      if (idx >= goldenDepth) begin
        abortRun("Golden file has no end record");
      end
      kind = golden[idx][35:32];
    end

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
source/cpuPkg.sv
source/registerFile.sv
source/alu.sv
source/instrDecoder.sv
source/pcUnit.sv
source/memorySystem.sv
source/processor.sv
dv/processorTb.sv

//--- dv/processorGolden.txt
// Word kind_target_addr_data. Kind 1 load (target 0 instr, 1 data), 2 run (data = output count)
// Kind 3 expected ioOut (data), 4 end PC low byte (data), 0 end of file
// Arithmetic with lda, add, sub and sta to the output address
1_1_000_1234 1_1_001_0FFF 1_1_002_0001 1_1_003_FFFF
1_0_000_4000 1_0_001_4401 1_0_002_0840 1_0_003_5BFF 1_0_004_1C40
1_0_005_5FFF 1_0_006_4803 1_0_007_4C02 1_0_008_02C0 1_0_009_53FF
1_0_00A_1780 1_0_00B_57FF 1_0_00C_7000
2_0_000_0004 3_0_000_2233 3_0_000_0235 3_0_000_0000 3_0_000_0002
4_0_000_000C
// Memory round trips through st/ld at a register address and sta/lda absolute
1_1_005_BEEF 1_1_006_0040 1_1_007_1357
1_0_000_4005 1_0_001_4406 1_0_002_3100 1_0_003_2900 1_0_004_5BFF
1_0_005_4C07 1_0_006_5C80 1_0_007_4080 1_0_008_53FF 1_0_009_0C80
1_0_00A_31C0 1_0_00B_2100 1_0_00C_53FF 1_0_00D_7000
2_0_000_0003 3_0_000_BEEF 3_0_000_1357 3_0_000_D246
4_0_000_000D
// Countdown loop with sub, bz and jmp back
1_1_000_0003 1_1_001_0001
1_0_000_4000 1_0_001_4401 1_0_002_53FF 1_0_003_1040 1_0_004_6002
1_0_005_73FD 1_0_006_53FF 1_0_007_7000
2_0_000_0004 3_0_000_0003 3_0_000_0002 3_0_000_0001 3_0_000_0000
4_0_000_0007
// Register jump over a store that must not run
1_1_000_0010 1_1_001_00A5 1_1_002_0003
1_0_000_4000 1_0_001_4401 1_0_002_8000 1_0_003_57FF 1_0_004_7000
1_0_010_4802 1_0_011_0D80 1_0_012_5FFF 1_0_013_7000
2_0_000_0001 3_0_000_00A8 4_0_000_0013
0_0_000_0000
